// File: design/gpu_host_macros.svh
// gpu host glue constants
// register map of the host bridge window, flag bit positions,
// field widths and the fixed video timing of the test pattern
`ifndef GPU_HOST_MACROS_SVH
`define GPU_HOST_MACROS_SVH

// host bridge register map, byte offsets
`define REG_GP0         8'h00
`define REG_GP1         8'h04
`define REG_FLAGS       8'h08
`define REG_DMA         8'h0C
`define REG_FB_HSIZE    8'h10
`define REG_FB_VSIZE    8'h14
`define REG_FB_FORMAT   8'h18
`define REG_FB_BASE     8'h1C
`define REG_FB_STRIDE   8'h20

// flags word write bits
`define FLAG_DMA_ACK_BIT 31  // one cycle ack pulse
`define FLAG_GPU_RUN_BIT 30  // gpu run level

// widths
`define BUS_ADDR_W      8
`define BUS_DATA_W      32
`define DEBUG_W         28   // debug count bits in the flags word
`define FB_HSIZE_W      12
`define FB_VSIZE_W      12
`define FB_FORMAT_W     6
`define FB_BASE_W       32
`define FB_STRIDE_W     14
`define PIXEL_W         8
`define HCOUNT_W        10
`define VCOUNT_W        9

// video timing, 768 clocks per line and 512 lines
`define H_LAST          10'd767
`define H_ACTIVE        10'd640
`define HS_SLOT         6'd45    // line position / 16
`define V_ACTIVE        9'd480
`define VS_FIRST        9'd500
`define VS_LAST         9'd506

`endif

// File: design/gpu_host_pkg.sv
// gpu host glue types
// bus request, gpu register port, framebuffer config and video bundles
`include "gpu_host_macros.svh"

package gpu_host_pkg;

	typedef logic [`BUS_ADDR_W-1:0]  bus_addr_t;   // byte offset in window
	typedef logic [`BUS_DATA_W-1:0]  bus_data_t;

	// one host cycle, 42 bits
	typedef struct packed {
		logic      write;
		logic      read;
		bus_addr_t addr;
		bus_data_t wdata;
	} bus_req_t;

	// cpu side strobes into the gpu, 36 bits
	typedef struct packed {
		logic      sel;
		logic      a2;       // 0 gp0, 1 gp1
		logic      write;
		logic      read;
		bus_data_t data;
	} gpu_port_t;

	// gpu status back to the bridge, 32 bits
	typedef struct packed {
		logic                  irq;
		logic                  dma_req;
		logic                  can_write;
		logic [`DEBUG_W-1:0]   debug_cnt;
		logic                  valid;    // read data valid
	} gpu_status_t;

	typedef logic [`FB_HSIZE_W-1:0]  fb_hsize_t;
	typedef logic [`FB_VSIZE_W-1:0]  fb_vsize_t;
	typedef logic [`FB_FORMAT_W-1:0] fb_format_t;
	typedef logic [`FB_BASE_W-1:0]   fb_base_t;
	typedef logic [`FB_STRIDE_W-1:0] fb_stride_t;

	// framebuffer geometry, 76 bits
	typedef struct packed {
		fb_hsize_t  hsize;
		fb_vsize_t  vsize;
		fb_format_t format;
		fb_base_t   base;
		fb_stride_t stride;
	} fb_cfg_t;

	typedef logic [`PIXEL_W-1:0]  pixel_t;
	typedef logic [`HCOUNT_W-1:0] hcount_t;
	typedef logic [`VCOUNT_W-1:0] vcount_t;

	// rgb plus syncs, 27 bits
	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
		logic   hs;
		logic   vs;
		logic   de;
	} video_t;

	typedef enum logic [1:0] {
		st_idle,
		st_write_done,
		st_read_wait
	} bridge_state_t;

endpackage

// File: design/gpu_bus_bridge.sv
// host bus to gpu register bridge
// turns host writes and reads of gp0/gp1/flags/dma into one cycle
// gpu strobes, holds waitrequest during gp register accesses
`timescale 1ns/1ps
`include "gpu_host_macros.svh"

module gpu_bus_bridge (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gpu_host_pkg::bus_req_t    i_req,
	input  gpu_host_pkg::gpu_status_t i_gpu_status,
	input  gpu_host_pkg::bus_data_t   i_gpu_data,
	input  logic                      i_hdmi_vbl,
	output logic                      o_waitrequest,
	output gpu_host_pkg::bus_data_t   o_readdata,
	output logic                      o_readvalid,
	output gpu_host_pkg::gpu_port_t   o_gpu,
	output logic                      o_gpu_run,
	output logic                      o_dma_ack
);

	gpu_host_pkg::bridge_state_t state;
	gpu_host_pkg::bus_data_t     cpu_data;   // write data toward the gpu
	gpu_host_pkg::bus_data_t     flag_word;
	logic                        gpu_sel;
	logic                        gpu_a2;
	logic                        gpu_wr;
	logic                        gpu_rd;
	logic                        take_write; // write sampled this edge
	logic                        take_read;  // read sampled this edge
	logic                        gp_addr;    // gp0 or gp1 offset

	// flags / debug word, msb first
	assign flag_word = {i_hdmi_vbl, i_gpu_status.dma_req, i_gpu_status.irq,
		i_gpu_status.can_write, i_gpu_status.debug_cnt};

	assign take_write = (state == gpu_host_pkg::st_idle) && i_req.write;
	assign take_read  = (state == gpu_host_pkg::st_idle) && !i_req.write && i_req.read;
	assign gp_addr    = (i_req.addr == `REG_GP0) || (i_req.addr == `REG_GP1);

	assign o_gpu = '{sel: gpu_sel, a2: gpu_a2, write: gpu_wr, read: gpu_rd, data: cpu_data};

	// ==============================
	// command fsm
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state         <= gpu_host_pkg::st_idle;
			o_waitrequest <= 1'b1;     // held until first clock
			o_readvalid   <= 1'b0;
			gpu_sel       <= 1'b0;
			gpu_a2        <= 1'b0;
			gpu_wr        <= 1'b0;
			gpu_rd        <= 1'b0;
			o_dma_ack     <= 1'b0;
			o_gpu_run     <= 1'b1;     // gpu starts running
		end else begin
			// strobes and pulses last one cycle
			gpu_sel     <= 1'b0;
			gpu_wr      <= 1'b0;
			gpu_rd      <= 1'b0;
			o_dma_ack   <= 1'b0;
			o_readvalid <= 1'b0;
			case (state)
				gpu_host_pkg::st_idle: begin
					o_waitrequest <= 1'b0;
					if (i_req.write) begin
						case (i_req.addr)
							`REG_GP0, `REG_GP1: begin
								gpu_a2        <= (i_req.addr == `REG_GP1);
								gpu_sel       <= 1'b1;
								gpu_wr        <= 1'b1;
								o_waitrequest <= 1'b1;
								state         <= gpu_host_pkg::st_write_done;
							end
							`REG_FLAGS: begin  // no gpu strobe here
								gpu_a2        <= 1'b0;
								o_dma_ack     <= i_req.wdata[`FLAG_DMA_ACK_BIT];
								o_gpu_run     <= i_req.wdata[`FLAG_GPU_RUN_BIT];
								o_waitrequest <= 1'b1;
								state         <= gpu_host_pkg::st_write_done;
							end
							`REG_DMA: begin  // dma push, sel stays low
								gpu_a2        <= 1'b0;
								gpu_wr        <= 1'b1;
								o_dma_ack     <= 1'b1;
								o_waitrequest <= 1'b1;
								state         <= gpu_host_pkg::st_write_done;
							end
							default: ;  // fb regs or unmapped, no wait
						endcase
					end else if (i_req.read) begin
						if (gp_addr) begin
							gpu_a2        <= (i_req.addr == `REG_GP1);
							gpu_sel       <= 1'b1;
							gpu_rd        <= 1'b1;
							o_waitrequest <= 1'b1;
							state         <= gpu_host_pkg::st_read_wait;
						end else begin
							o_readvalid <= 1'b1;  // flags, dma or unmapped
						end
					end
				end
				gpu_host_pkg::st_write_done: begin
					o_waitrequest <= 1'b0;
					state         <= gpu_host_pkg::st_idle;
				end
				gpu_host_pkg::st_read_wait: begin
					if (i_gpu_status.valid) begin  // latency set by the gpu
						o_readvalid   <= 1'b1;
						o_waitrequest <= 1'b0;
						state         <= gpu_host_pkg::st_idle;
					end
				end
				default: state <= gpu_host_pkg::st_idle;
			endcase
		end
	end

	// ==============================
	// data path
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (take_write && (gp_addr || i_req.addr == `REG_DMA))
			cpu_data <= i_req.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (take_read && !gp_addr) begin
			case (i_req.addr)
				`REG_FLAGS: o_readdata <= flag_word;
				`REG_DMA:   o_readdata <= i_gpu_data;  // no gpu strobe
				default:    o_readdata <= '0;
			endcase
		end else if (state == gpu_host_pkg::st_read_wait && i_gpu_status.valid) begin
			o_readdata <= i_gpu_data;
		end
	end

	// gpu strobes are single cycle pulses
	a_strobe_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(gpu_sel || gpu_wr || gpu_rd) |=> !(gpu_sel || gpu_wr || gpu_rd));

	// read data only handed back while the bus is released
	a_valid_no_wait: assert property (@(posedge clk_sys) disable iff (reset)
		o_readvalid |-> !o_waitrequest);

endmodule

// File: design/fb_config_regs.sv
// framebuffer config registers
// size, format, base and stride loaded from host bus writes
`timescale 1ns/1ps
`include "gpu_host_macros.svh"

module fb_config_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  gpu_host_pkg::bus_req_t i_req,
	output gpu_host_pkg::fb_cfg_t  o_fb_cfg
);

	// ==============================
	// register bank
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			o_fb_cfg <= '0;
		end else if (i_req.write) begin
			// low bits of the write word at each field width
			case (i_req.addr)
				`REG_FB_HSIZE:  o_fb_cfg.hsize  <= i_req.wdata[`FB_HSIZE_W-1:0];
				`REG_FB_VSIZE:  o_fb_cfg.vsize  <= i_req.wdata[`FB_VSIZE_W-1:0];
				`REG_FB_FORMAT: o_fb_cfg.format <= i_req.wdata[`FB_FORMAT_W-1:0];
				`REG_FB_BASE:   o_fb_cfg.base   <= i_req.wdata[`FB_BASE_W-1:0];
				`REG_FB_STRIDE: o_fb_cfg.stride <= i_req.wdata[`FB_STRIDE_W-1:0];
				default: ;  // bridge offsets, not ours
			endcase
		end
	end

	// config only moves on a host write
	a_cfg_hold: assert property (@(posedge clk_sys) disable iff (reset)
		!i_req.write |=> $stable(o_fb_cfg));

endmodule

// File: design/video_test_pattern.sv
// free running video timing with an xor test pattern
// 768 clocks per line, 512 lines, 640x480 active
`timescale 1ns/1ps
`include "gpu_host_macros.svh"

module video_test_pattern (
	input  logic                 clk_sys,
	input  logic                 reset,
	output gpu_host_pkg::video_t o_video
);

	gpu_host_pkg::hcount_t hcount;
	gpu_host_pkg::vcount_t vcount;   // 0..511, natural wrap

	// ==============================
	// counters
	// ==============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == `H_LAST) begin
			hcount <= '0;
			vcount <= vcount + 1'b1;  // next line
		end else begin
			hcount <= hcount + 1'b1;
		end
	end

	// ==============================
	// sync and enable
	// ==============================
	// hs is one 16 clock slot near the line end
	assign o_video.hs = (hcount[9:4] == `HS_SLOT);
	assign o_video.vs = (vcount >= `VS_FIRST) && (vcount <= `VS_LAST);
	assign o_video.de = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

	// xor pattern, each channel a different slice
	assign o_video.r = hcount[7:0] ^ vcount[8:1];
	assign o_video.g = hcount[8:1] ^ vcount[7:0];
	assign o_video.b = hcount[9:2] ^ vcount[8:1];

	// sync slot lies outside the active line
	a_de_hs: assert property (@(posedge clk_sys) disable iff (reset)
		!(o_video.de && o_video.hs));

endmodule

// File: design/gpu_host_top.sv
// gpu host glue top level
// host bus bridge to the gpu register port, framebuffer config
// registers and the video test pattern generator
`timescale 1ns/1ps

module gpu_host_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gpu_host_pkg::bus_req_t    i_req,
	input  gpu_host_pkg::gpu_status_t i_gpu_status,
	input  gpu_host_pkg::bus_data_t   i_gpu_data,
	input  logic                      i_hdmi_vbl,
	output logic                      o_waitrequest,
	output gpu_host_pkg::bus_data_t   o_readdata,
	output logic                      o_readvalid,
	output gpu_host_pkg::gpu_port_t   o_gpu,
	output logic                      o_gpu_run,
	output logic                      o_dma_ack,
	output gpu_host_pkg::fb_cfg_t     o_fb_cfg,
	output gpu_host_pkg::video_t      o_video
);

	// ==============================
	// host side
	// ==============================
	gpu_bus_bridge u_bridge (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_req         (i_req),
		.i_gpu_status  (i_gpu_status),
		.i_gpu_data    (i_gpu_data),
		.i_hdmi_vbl    (i_hdmi_vbl),      // flags word only
		.o_waitrequest (o_waitrequest),
		.o_readdata    (o_readdata),
		.o_readvalid   (o_readvalid),
		.o_gpu         (o_gpu),
		.o_gpu_run     (o_gpu_run),
		.o_dma_ack     (o_dma_ack)
	);

	// same request, fb offsets only
	fb_config_regs u_fb_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.i_req    (i_req),
		.o_fb_cfg (o_fb_cfg)
	);

	// ==============================
	// video side
	// ==============================
	video_test_pattern u_pattern (
		.clk_sys (clk_sys),
		.reset   (reset),
		.o_video (o_video)
	);

endmodule

// File: dv/tb_gpu_host_top.sv
// testbench for the gpu host glue top level
// table of host bus transactions against a gpu read model, plus a
// reference count check of the video test pattern
`timescale 1ns/1ps
`include "gpu_host_macros.svh"

module tb_gpu_host_top;

	localparam int frame_cycles = 768 * 512;
	localparam int wait_limit   = 40;   // cycles per bus transaction

	// strobe kind of a table entry
	localparam logic [2:0] kind_none   = 3'd0;
	localparam logic [2:0] kind_gp_wr  = 3'd1;
	localparam logic [2:0] kind_gp_rd  = 3'd2;
	localparam logic [2:0] kind_dma_wr = 3'd3;
	localparam logic [2:0] kind_flags  = 3'd4;

	typedef struct packed {
		logic                    is_read;
		gpu_host_pkg::bus_addr_t addr;
		gpu_host_pkg::bus_data_t wdata;
		logic [3:0]              delay;   // gpu read latency
		gpu_host_pkg::bus_data_t gdata;   // gpu read data
		gpu_host_pkg::bus_data_t exp;     // expected o_readdata
		logic [2:0]              kind;
	} entry_t;

	logic                      clk_sys = 1'b0;
	logic                      reset;
	gpu_host_pkg::bus_req_t    req;
	gpu_host_pkg::gpu_status_t status_drv;  // valid bit comes from the model
	logic                      gpu_valid = 1'b0;
	gpu_host_pkg::bus_data_t   gpu_data;
	logic                      hdmi_vbl;
	logic                      waitrequest;
	gpu_host_pkg::bus_data_t   readdata;
	logic                      readvalid;
	gpu_host_pkg::gpu_port_t   gpu;
	logic                      gpu_run;
	logic                      dma_ack;
	gpu_host_pkg::fb_cfg_t     fb_cfg;
	gpu_host_pkg::video_t      video;

	entry_t                    table_q[$];
	logic [31:0]               rng_state = 32'h21dc_9f0a;
	gpu_host_pkg::fb_cfg_t     exp_fb;
	logic                      exp_run;
	int                        gpu_delay = 0;
	int                        gpu_wait = 0;
	logic                      gpu_busy = 1'b0;
	gpu_host_pkg::hcount_t     ref_h;
	gpu_host_pkg::vcount_t     ref_v;
	int                        frames;      // full frames since reset release
	logic                      video_on;
	int                        vid_tick = 0;
	int                        vid_checks = 0;
	int                        vid_errs = 0;
	int                        checks = 0;
	int                        value_errs = 0;
	int                        other_errs = 0;
	int                        cycle_count = 0;
	int                        cycle_limit = 2 * frame_cycles;

	always #5 clk_sys = ~clk_sys;

	gpu_host_top u_gpu_host_top (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_req         (req),
		.i_gpu_status  ({status_drv[31:1], gpu_valid}),
		.i_gpu_data    (gpu_data),
		.i_hdmi_vbl    (hdmi_vbl),
		.o_waitrequest (waitrequest),
		.o_readdata    (readdata),
		.o_readvalid   (readvalid),
		.o_gpu         (gpu),
		.o_gpu_run     (gpu_run),
		.o_dma_ack     (dma_ack),
		.o_fb_cfg      (fb_cfg),
		.o_video       (video)
	);

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);   // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// expected sync and colour for one count pair
	function automatic gpu_host_pkg::video_t expect_video(input gpu_host_pkg::hcount_t h,
		input gpu_host_pkg::vcount_t v);
		gpu_host_pkg::video_t x;
		x.hs = ((h / 10'd16) == 10'd45);
		x.vs = (v >= `VS_FIRST) && (v <= `VS_LAST);
		x.de = (h < `H_ACTIVE) && (v < `V_ACTIVE);
		x.r  = 8'(h % 256) ^ 8'(v / 2);
		x.g  = 8'(h / 2) ^ 8'(v % 256);
		x.b  = 8'(h / 4) ^ 8'(v / 2);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %s got %h exp %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_fb();
		checks++;
		assert (fb_cfg === exp_fb) else begin
			$display("[FAIL] o_fb_cfg got %h exp %h", fb_cfg, exp_fb);
			value_errs++;
		end
	endtask

	task automatic add_entry(input logic rd, input gpu_host_pkg::bus_addr_t addr,
		input gpu_host_pkg::bus_data_t wdata, input logic [3:0] delay,
		input gpu_host_pkg::bus_data_t gdata, input gpu_host_pkg::bus_data_t exp,
		input logic [2:0] kind);
		entry_t e;
		e = '{rd, addr, wdata, delay, gdata, exp, kind};
		table_q.push_back(e);
	endtask

	// ==============================
	// one bus transaction
	// ==============================
	task automatic run_entry(input entry_t e);
		int                      n_sel;
		int                      n_wr;
		int                      n_rd;
		int                      n_ack;
		int                      cyc;
		logic                    done;
		logic                    seen_a2;
		gpu_host_pkg::bus_data_t seen_data;
		n_sel     = 0;
		n_wr      = 0;
		n_rd      = 0;
		n_ack     = 0;
		cyc       = 0;
		done      = 1'b0;
		seen_a2   = 1'b0;
		seen_data = '0;
		while (waitrequest && cyc < wait_limit) begin  // bus busy
			@(negedge clk_sys);
			cyc++;
		end
		gpu_delay = int'(e.delay);
		gpu_data  = e.gdata;
		req = '{write: !e.is_read, read: e.is_read, addr: e.addr, wdata: e.wdata};
		@(negedge clk_sys);   // sampled on the rising edge just passed
		req.write = 1'b0;
		req.read  = 1'b0;
		cyc = 0;
		while (!done && cyc < wait_limit) begin
			if (gpu.sel) n_sel++;
			if (gpu.write) n_wr++;
			if (gpu.read) n_rd++;
			if (dma_ack) n_ack++;
			if (gpu.sel)
				seen_a2 = gpu.a2;
			if (gpu.write)
				seen_data = gpu.data;
			if (e.is_read ? readvalid : !waitrequest) begin
				done = 1'b1;
			end else begin
				@(negedge clk_sys);
				cyc++;
			end
		end
		assert (done) else begin
			$display("bus access to offset %h did not complete in %0d cycles",
				e.addr, wait_limit);
			other_errs++;
		end
		// gp reads wait out the model latency, register writes hold one cycle
		check_value("completion cycles", cyc,
			(e.kind == kind_gp_rd) ? int'(e.delay) + 1 :
			(e.kind == kind_gp_wr || e.kind == kind_dma_wr || e.kind == kind_flags) ? 1 : 0);
		if (e.kind == kind_flags)
			exp_run = e.wdata[`FLAG_GPU_RUN_BIT];
		if (!e.is_read) begin
			case (e.addr)
				`REG_FB_HSIZE:  exp_fb.hsize  = e.wdata[11:0];
				`REG_FB_VSIZE:  exp_fb.vsize  = e.wdata[11:0];
				`REG_FB_FORMAT: exp_fb.format = e.wdata[5:0];
				`REG_FB_BASE:   exp_fb.base   = e.wdata;
				`REG_FB_STRIDE: exp_fb.stride = e.wdata[13:0];
				default: ;
			endcase
		end
		check_value("o_gpu.sel count", n_sel,
			(e.kind == kind_gp_wr || e.kind == kind_gp_rd) ? 1 : 0);
		check_value("o_gpu.write count", n_wr,
			(e.kind == kind_gp_wr || e.kind == kind_dma_wr) ? 1 : 0);
		check_value("o_gpu.read count", n_rd, (e.kind == kind_gp_rd) ? 1 : 0);
		check_value("o_dma_ack count", n_ack,
			(e.kind == kind_dma_wr || (e.kind == kind_flags && e.wdata[31])) ? 1 : 0);
		if (n_sel > 0)
			check_value("o_gpu.a2", 32'(seen_a2), 32'(e.addr == `REG_GP1));
		if (e.kind == kind_gp_wr || e.kind == kind_dma_wr)
			check_value("o_gpu.data", seen_data, e.wdata);
		if (e.is_read)
			check_value("o_readdata", readdata, e.exp);
		check_value("o_gpu_run", 32'(gpu_run), 32'(exp_run));
		check_fb();
	endtask

	// gpu model, valid after the entry's latency
	always @(negedge clk_sys) begin
		gpu_valid = 1'b0;
		if (gpu.sel && gpu.read) begin
			gpu_busy = 1'b1;
			gpu_wait = gpu_delay;
		end
		if (gpu_busy) begin
			if (gpu_wait == 0) begin
				gpu_valid = 1'b1;
				gpu_busy  = 1'b0;
			end else begin
				gpu_wait = gpu_wait - 1;
			end
		end
	end

	// ==============================
	// video reference and checker
	// ==============================
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ref_h    <= '0;
			ref_v    <= '0;
			frames   <= 0;
			video_on <= 1'b0;
		end else begin
			video_on <= 1'b1;
			if (ref_h == `H_LAST) begin
				ref_h <= '0;
				ref_v <= ref_v + 9'd1;   // wraps after 511
				if (ref_v == 9'd511)
					frames <= frames + 1;
			end else begin
				ref_h <= ref_h + 10'd1;
			end
		end
	end

	always @(negedge clk_sys) begin
		gpu_host_pkg::video_t exp_v;
		if (video_on) begin
			vid_tick++;
			if (vid_tick % 7 == 0) begin   // every seventh cycle, drifts across the line
				exp_v = expect_video(ref_h, ref_v);
				vid_checks++;
				assert (video === exp_v) else begin
					$display("[FAIL] o_video got %h exp %h at h %h v %h",
						video, exp_v, ref_h, ref_v);
					vid_errs++;
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("run stopped at the cycle limit of %0d", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ==============================
	// main sequence
	// ==============================
	initial begin
		logic [31:0]             r;
		logic [31:0]             d;
		gpu_host_pkg::bus_data_t flags_exp;
		reset                = 1'b1;
		req                  = '0;
		gpu_data             = '0;
		hdmi_vbl             = 1'b1;
		status_drv           = '0;
		status_drv.irq       = 1'b1;
		status_drv.can_write = 1'b1;
		r                    = next_rand();
		status_drv.debug_cnt = r[27:0];
		exp_fb               = '0;
		exp_run              = 1'b1;
		flags_exp = {hdmi_vbl, status_drv.dma_req, status_drv.irq, status_drv.can_write,
			status_drv.debug_cnt};

		add_entry(1'b0, `REG_GP0, 32'h1234_5678, '0, '0, '0, kind_gp_wr);
		add_entry(1'b0, `REG_GP1, 32'h9abc_def0, '0, '0, '0, kind_gp_wr);
		add_entry(1'b0, `REG_DMA, 32'h0bad_f00d, '0, '0, '0, kind_dma_wr);
		for (int i = 0; i < 6; i++) begin   // random latency and data
			r = next_rand();
			d = next_rand();
			add_entry(1'b1, (i % 2 == 0) ? `REG_GP0 : `REG_GP1, '0, d[3:0], r, r, kind_gp_rd);
		end
		add_entry(1'b0, `REG_FLAGS, 32'h8000_0000, '0, '0, '0, kind_flags);  // ack, run low
		add_entry(1'b0, `REG_FLAGS, 32'h4000_0000, '0, '0, '0, kind_flags);  // run high again
		add_entry(1'b1, `REG_FLAGS, '0, '0, '0, flags_exp, kind_none);
		r = next_rand();
		add_entry(1'b1, `REG_DMA, '0, '0, r, r, kind_none);
		add_entry(1'b0, `REG_FB_HSIZE, next_rand(), '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_VSIZE, next_rand(), '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_FORMAT, next_rand(), '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_BASE, next_rand(), '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_STRIDE, next_rand(), '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_HSIZE, 32'hffff_ffff, '0, '0, '0, kind_none);
		add_entry(1'b0, `REG_FB_STRIDE, 32'hffff_ffff, '0, '0, '0, kind_none);
		add_entry(1'b0, 8'h40, 32'h5555_aaaa, '0, '0, '0, kind_none);  // unmapped
		add_entry(1'b1, 8'h44, '0, '0, '0, '0, kind_none);             // unmapped reads zero
		cycle_limit = table_q.size() * wait_limit + 2 * frame_cycles;

		repeat (2) @(negedge clk_sys);
		check_value("o_gpu_run", 32'(gpu_run), 32'h1);
		check_value("o_gpu strobes", 32'({gpu.sel, gpu.write, gpu.read}), '0);
		check_value("o_dma_ack", 32'(dma_ack), '0);
		check_value("o_waitrequest", 32'(waitrequest), 32'h1);
		check_fb();
		reset = 1'b0;
		@(negedge clk_sys);
		assert (!waitrequest) else begin
			$display("waitrequest still high one cycle after reset release");
			other_errs++;
		end

		foreach (table_q[i])
			run_entry(table_q[i]);
		while (frames < 1)   // let the checker see a whole frame
			@(negedge clk_sys);

		$display("checks %0d, value errors %0d, other errors %0d",
			checks + vid_checks, value_errs + vid_errs, other_errs);
		if (value_errs + vid_errs + other_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/gpu_host_pkg.sv
design/gpu_bus_bridge.sv
design/fb_config_regs.sv
design/video_test_pattern.sv
design/gpu_host_top.sv
dv/tb_gpu_host_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the gpu host glue testbench with verilator
# exit status follows the pass message in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_gpu_host_top -Mdir obj_dir \
	|| { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_gpu_host_top)
echo "$sim_out"
echo "$sim_out" | grep -q "^TESTBENCH PASSED$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
